//--- load_unit_top.f
+incdir+hdl
+incdir+bench
hdl/load_unit_pkg.sv
hdl/command_front.sv
hdl/load_sequencer.sv
hdl/bus_port.sv
hdl/load_unit_top.sv
bench/mem_responder.sv
bench/load_unit_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' load_unit_top.f)
HDRS := $(wildcard hdl/*.svh bench/*.svh)

obj_dir/Vload_unit_tb: load_unit_top.f $(SRCS) $(HDRS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f load_unit_top.f --top-module load_unit_tb -o Vload_unit_tb

run: obj_dir/Vload_unit_tb
	./obj_dir/Vload_unit_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- bench/mem_image.svh
`include "load_unit_params.svh"

function automatic logic [15:0] mem_word(input logic [`LU_PADDR_W-2:0] addr);
    logic [31:0] wide;
    logic [31:0] product;
    wide    = 32'(addr);
    product = wide * 32'd40503;
    return product[15:0] ^ wide[`LU_PADDR_W-2:3];    // Every address bit shapes the word.
endfunction

//--- bench/load_unit_tb.sv
`timescale 1ns/1ps
`include "load_unit_params.svh"

module load_unit_tb;

    `include "mem_image.svh"

    localparam int num_commands = 229;    // All commands of the five tests.
    localparam int load_cycles  = 2 * (`LU_MAX_WAIT + 3) + 4;
    localparam int limit_ns     = num_commands * load_cycles * 20 * 2 + 2000;
    localparam logic [15:0] byte_offsets [8] = '{16'h0000, 16'h0001, 16'h1234, 16'h1235,
                                                 16'hFFFE, 16'hFFFF, 16'h8000, 16'h7FFF};
    localparam logic [15:0] even_offsets [6] = '{16'h0000, 16'h0002, 16'h1000, 16'h7FFE,
                                                 16'hFFFE, 16'hABCC};
    localparam logic [15:0] odd_offsets [6]  = '{16'h0001, 16'h0003, 16'hFFFF, 16'hFFFF,
                                                 16'h1235, 16'h7FFF};

    logic                       clk;
    logic                       reset;
    load_unit_pkg::lu_cmd_t     cmd;
    logic                       cmd_strobe;
    logic                       busy;
    logic [15:0]                result;
    logic                       result_strobe;
    load_unit_pkg::lu_bus_req_t mem_req;
    logic [15:0]                mem_rdata;
    logic                       mem_ready;

    logic [15:0] seg_model [`LU_SEG_COUNT];
    logic [15:0] expected_q [$];
    string       test_name;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          failed_tests = 0;
    int          checks = 0;
    int          bus_reads = 0;
    int          results_seen = 0;
    int          loads_issued = 0;

    load_unit_top uut (.*);
    mem_responder responder (.*);

    always #10 clk = ~clk;

    // ##############################
    // Reference model
    // ##############################

    function automatic logic [7:0] image_byte(input logic [`LU_PADDR_W-1:0] p);
        logic [15:0] word;
        word = mem_word(p[`LU_PADDR_W-1:1]);
        return p[0] ? word[15:8] : word[7:0];    // Even addresses sit in the low lane.
    endfunction

    function automatic logic [15:0] expected_load(input bit is_byte, input logic [15:0] seg,
                                                  input logic [15:0] offset);
        logic [`LU_PADDR_W-1:0] base;
        logic [15:0]            next_offset;
        base        = {seg, 4'h0};
        next_offset = offset + 16'd1;    // The high byte wraps inside the segment.
        if (is_byte) begin
            return {8'h00, image_byte(base + {4'h0, offset})};
        end
        return {image_byte(base + {4'h0, next_offset}), image_byte(base + {4'h0, offset})};
    endfunction

    // ##############################
    // Monitors
    // ##############################

    always @(posedge clk) begin
        if (mem_req.read && mem_ready) begin
            bus_reads++;
        end
    end

    always @(posedge clk) begin
        logic [15:0] want;
        if (!reset && result_strobe) begin
            results_seen++;
            checks++;
            assert (expected_q.size() > 0) else begin
                $display("Unexpected result strobe in %s with no load outstanding", test_name);
                test_errors++;
            end
            if (expected_q.size() > 0) begin
                want = expected_q.pop_front();
                assert (result == want) else begin
                    $display("** Error %s: expected %h, actual %h", test_name, want, result);
                    test_errors++;
                end
            end
        end
    end

    initial begin
        #(limit_ns);
        $display("Watchdog expired after %0d ns during %s", limit_ns, test_name);
        $display("TESTS FAILED");
        $finish;
    end

    // ##############################
    // Stimulus
    // ##############################

    task automatic send(input load_unit_pkg::lu_cmd_t c, input bit hold);
        load_unit_pkg::lu_cmd_t other;
        other        = c;
        other.opcode = (c.opcode == load_unit_pkg::LOAD_BYTE) ? load_unit_pkg::LOAD_WORD :
                                                                 load_unit_pkg::LOAD_BYTE;
        other.seg    = load_unit_pkg::lu_seg_e'(2'(c.seg + 2'd1));
        other.offset = ~c.offset;
        @(posedge clk);
        cmd        <= c;
        cmd_strobe <= 1'b1;
        @(posedge clk);
        if (hold) begin
            cmd <= other;      // A different command here must leave no trace.
            @(posedge clk);    // This second strobe cycle meets busy high.
        end
        cmd_strobe <= 1'b0;
    endtask

    task automatic set_segment(input load_unit_pkg::lu_seg_e seg, input logic [15:0] value);
        load_unit_pkg::lu_cmd_t c;
        c        = '0;
        c.opcode = load_unit_pkg::SET_SEGMENT;
        c.seg    = seg;
        c.data   = value;
        send(c, 1'b0);
        seg_model[seg] = value;
        @(posedge clk);
        checks++;
        assert (!busy) else begin
            $display("Busy rose after a segment write in %s", test_name);
            test_errors++;
        end
    endtask

    task automatic do_load(input bit is_byte, input load_unit_pkg::lu_seg_e seg,
                           input logic [15:0] offset, input bit hold);
        load_unit_pkg::lu_cmd_t c;
        int reads_before;
        int reads_expected;
        c              = '0;
        c.opcode       = is_byte ? load_unit_pkg::LOAD_BYTE : load_unit_pkg::LOAD_WORD;
        c.seg          = seg;
        c.offset       = offset;
        reads_expected = (is_byte || !offset[0]) ? 1 : 2;
        reads_before   = bus_reads;
        expected_q.push_back(expected_load(is_byte, seg_model[seg], offset));
        loads_issued++;
        send(c, hold);
        do begin
            @(posedge clk);
        end while (busy);
        checks += 2;
        assert (results_seen == loads_issued) else begin
            $display("Result count off in %s: %0d loads gave %0d results", test_name,
                     loads_issued, results_seen);
            test_errors++;
        end
        assert (bus_reads - reads_before == reads_expected) else begin
            $display("** Error %s: expected %0d bus reads, actual %0d", test_name,
                     reads_expected, bus_reads - reads_before);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("Test %-16s ok", test_name);
        end else begin
            $display("Test %-16s %0d errors", test_name, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
    endtask

    initial begin
        int                      pick;
        load_unit_pkg::lu_seg_e  rseg;
        void'($urandom(94174));
        clk        = 1'b0;
        reset      = 1'b1;
        cmd        = '0;
        cmd_strobe = 1'b0;
        test_name  = "reset";
        for (int s = 0; s < `LU_SEG_COUNT; s++) begin
            seg_model[s] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        start_test("segment_writes");
        set_segment(load_unit_pkg::SEG_ES, 16'h1000);
        set_segment(load_unit_pkg::SEG_CS, 16'h2345);
        set_segment(load_unit_pkg::SEG_SS, 16'h0007);
        set_segment(load_unit_pkg::SEG_DS, 16'hFFF0);
        for (int s = 0; s < 4; s++) begin
            do_load(1'b1, load_unit_pkg::lu_seg_e'(2'(s)), 16'h0123, 1'b0);
        end
        finish_test();

        start_test("byte_loads");
        for (int i = 0; i < 8; i++) begin
            do_load(1'b1, load_unit_pkg::SEG_DS, byte_offsets[i], 1'b0);
        end
        finish_test();

        start_test("aligned_words");
        for (int i = 0; i < 6; i++) begin
            do_load(1'b0, load_unit_pkg::lu_seg_e'(2'(i)), even_offsets[i], 1'b0);
        end
        finish_test();

        start_test("unaligned_words");
        set_segment(load_unit_pkg::SEG_SS, 16'h0FFF);
        for (int i = 0; i < 6; i++) begin
            do_load(1'b0, load_unit_pkg::lu_seg_e'(2'(i)), odd_offsets[i], 1'b0);
        end
        finish_test();

        start_test("random_mix");
        for (int i = 0; i < 200; i++) begin
            pick = $urandom_range(2, 0);
            rseg = load_unit_pkg::lu_seg_e'(2'($urandom_range(3, 0)));
            if (pick == 2) begin
                set_segment(rseg, 16'($urandom()));
            end else begin
                do_load(pick == 0, rseg, 16'($urandom()), $urandom_range(3, 0) == 0);
            end
        end
        repeat (4) @(posedge clk);
        checks++;
        assert (expected_q.size() == 0 && results_seen == loads_issued) else begin
            $display("Run ended with %0d results for %0d loads", results_seen, loads_issued);
            test_errors++;
        end
        finish_test();

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors", tests_run,
                 failed_tests, checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/mem_responder.sv
`timescale 1ns/1ps
`include "load_unit_params.svh"

module mem_responder (
    input  logic                       clk,
    input  logic                       reset,
    input  load_unit_pkg::lu_bus_req_t mem_req,
    output logic [15:0]                mem_rdata,
    output logic                       mem_ready
);

    `include "mem_image.svh"

    int unsigned wait_left;
    logic        serving;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            serving   <= 1'b0;
            wait_left <= 0;
        end else begin
            mem_ready <= 1'b0;
            if (serving) begin
                if (wait_left == 0) begin
                    mem_ready <= 1'b1;
                    mem_rdata <= mem_word(mem_req.addr);
                    serving   <= 1'b0;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else if (mem_req.read && !mem_ready) begin
                serving   <= 1'b1;
                wait_left <= $urandom_range(`LU_MAX_WAIT, 0);    // Fresh wait run per read.
            end
        end
    end

endmodule

//--- hdl/load_unit_top.sv
`timescale 1ns/1ps
`include "load_unit_params.svh"

module load_unit_top (
    input  logic                        clk,
    input  logic                        reset,
    // Command side.
    input  load_unit_pkg::lu_cmd_t      cmd,
    input  logic                        cmd_strobe,
    output logic                        busy,
    output logic [15:0]                 result,
    output logic                        result_strobe,
    // External word bus.
    output load_unit_pkg::lu_bus_req_t  mem_req,
    input  logic [15:0]                 mem_rdata,
    input  logic                        mem_ready
);

    logic                       write_mar;
    logic [`LU_OFFSET_W-1:0]    mar_in;
    logic [`LU_OFFSET_W-1:0]    segment;
    logic                       is_8bit;
    logic                       start;
    logic                       complete;
    load_unit_pkg::lu_bus_req_t bus_req;
    logic                       access;
    logic                       ack;
    logic [15:0]                ack_data;

    assign result_strobe = complete;

    // ##############################
    // Blocks
    // ##############################

    command_front u_front (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .complete   (complete),
        .busy       (busy),
        .write_mar  (write_mar),
        .mar_in     (mar_in),
        .segment    (segment),
        .is_8bit    (is_8bit),
        .start      (start)
    );

    load_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .write_mar  (write_mar),
        .mar_in     (mar_in),
        .segment    (segment),
        .start      (start),
        .is_8bit    (is_8bit),
        .bus_req    (bus_req),
        .access     (access),
        .ack        (ack),
        .ack_data   (ack_data),
        .mdr_out    (result),
        .complete   (complete)
    );

    bus_port u_bus (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .access     (access),
        .ack        (ack),
        .ack_data   (ack_data),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

endmodule

//--- hdl/bus_port.sv
`timescale 1ns/1ps

module bus_port (
    input  logic                        clk,
    input  logic                        reset,
    // Sequencer side.
    input  load_unit_pkg::lu_bus_req_t  bus_req,
    input  logic                        access,
    output logic                        ack,
    output logic [15:0]                 ack_data,
    // External word bus.
    output load_unit_pkg::lu_bus_req_t  mem_req,
    input  logic [15:0]                 mem_rdata,
    input  logic                        mem_ready
);

    logic outstanding;
    logic finishing;

    assign outstanding = mem_req.read;
    assign finishing   = outstanding && mem_ready;

    // ##############################
    // Request register
    // ##############################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_req <= '0;
            ack     <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (outstanding) begin
                // Address stays on the bus through every wait state.
                if (mem_ready) begin
                    mem_req.read <= 1'b0;
                    ack          <= 1'b1;
                end
            end else if (access) begin
                mem_req <= bus_req;
            end
        end
    end

    // ##############################
    // Read data capture
    // ##############################

    always_ff @(posedge clk) begin
        if (finishing) begin
            ack_data <= mem_rdata;    // Valid alongside ack.
        end
    end

endmodule

//--- hdl/load_sequencer.sv
`timescale 1ns/1ps
`include "load_unit_params.svh"

module load_sequencer (
    input  logic                        clk,
    input  logic                        reset,
    // Memory address register.
    input  logic                        write_mar,
    input  logic [`LU_OFFSET_W-1:0]     mar_in,
    input  logic [`LU_OFFSET_W-1:0]     segment,
    // Control.
    input  logic                        start,
    input  logic                        is_8bit,
    // Bus port side.
    output load_unit_pkg::lu_bus_req_t  bus_req,
    output logic                        access,
    input  logic                        ack,
    input  logic [15:0]                 ack_data,
    // Result.
    output logic [15:0]                 mdr_out,
    output logic                        complete
);

    load_unit_pkg::lu_seq_state_e state;
    logic [`LU_OFFSET_W-1:0] mar;
    logic [15:0] mdr;
    logic unaligned;
    logic fetching;
    logic last_read;

    // ##############################
    // Bus request
    // ##############################

    assign fetching = (state == load_unit_pkg::FIRST) || (state == load_unit_pkg::SECOND);

    // Segment times 8 plus the offset word index gives the word address.
    assign bus_req.addr = {segment, 3'b000} + {4'b0000, mar[`LU_OFFSET_W-1:1]};
    assign bus_req.read = fetching;
    assign access       = fetching && !ack;    // Let go as soon as the ack shows up.

    assign complete = (state == load_unit_pkg::DONE);
    assign mdr_out  = mdr;

    // A byte or an aligned word finishes on the first read.
    assign last_read = (state == load_unit_pkg::SECOND) || is_8bit || !unaligned;

    // ##############################
    // State and MAR
    // ##############################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= load_unit_pkg::IDLE;
            unaligned <= 1'b0;
            mar       <= '0;
        end else begin
            if (ack) begin
                mar <= mar + 1'b1;    // Wraps inside the segment.
            end else if (write_mar) begin
                mar <= mar_in;
            end

            case (state)
                load_unit_pkg::IDLE: begin
                    if (start) begin
                        state     <= load_unit_pkg::FIRST;
                        unaligned <= mar[0];
                    end
                end
                load_unit_pkg::FIRST,
                load_unit_pkg::SECOND: begin
                    if (ack) begin
                        state <= last_read ? load_unit_pkg::DONE : load_unit_pkg::SECOND;
                    end
                end
                default: begin
                    state <= load_unit_pkg::IDLE;
                end
            endcase
        end
    end

    // ##############################
    // Byte lane assembly
    // ##############################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mdr <= '0;
        end else if (start && state == load_unit_pkg::IDLE) begin
            mdr <= '0;
        end else if (ack && state == load_unit_pkg::FIRST) begin
            if (is_8bit) begin
                // Odd offsets live in the high lane.
                mdr <= {8'h00, unaligned ? ack_data[15:8] : ack_data[7:0]};
            end else if (unaligned) begin
                mdr[7:0] <= ack_data[15:8];    // Low half of a split word.
            end else begin
                mdr <= ack_data;
            end
        end else if (ack && state == load_unit_pkg::SECOND) begin
            mdr[15:8] <= ack_data[7:0];
        end
    end

endmodule

//--- hdl/command_front.sv
`timescale 1ns/1ps
`include "load_unit_params.svh"

module command_front (
    input  logic                    clk,
    input  logic                    reset,
    input  load_unit_pkg::lu_cmd_t  cmd,
    input  logic                    cmd_strobe,
    input  logic                    complete,
    output logic                    busy,
    output logic                    write_mar,
    output logic [`LU_OFFSET_W-1:0] mar_in,
    output logic [`LU_OFFSET_W-1:0] segment,
    output logic                    is_8bit,
    output logic                    start
);

    logic [`LU_OFFSET_W-1:0] seg_regs [`LU_SEG_COUNT];
    load_unit_pkg::lu_front_state_e state;
    logic accept;
    logic is_load;

    assign accept  = cmd_strobe && !busy;    // Strobes during a load are dropped.
    assign is_load = (cmd.opcode == load_unit_pkg::LOAD_BYTE) ||
                     (cmd.opcode == load_unit_pkg::LOAD_WORD);

    // ##############################
    // Segment register file
    // ##############################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `LU_SEG_COUNT; i++) begin
                seg_regs[i] <= '0;
            end
        end else if (accept && cmd.opcode == load_unit_pkg::SET_SEGMENT) begin
            seg_regs[cmd.seg] <= cmd.data;
        end
    end

    // ##############################
    // Load sequencing
    // ##############################

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= load_unit_pkg::READY;
            busy      <= 1'b0;
            write_mar <= 1'b0;
            start     <= 1'b0;
        end else begin
            write_mar <= 1'b0;
            start     <= 1'b0;
            case (state)
                load_unit_pkg::READY: begin
                    if (accept && is_load) begin
                        state     <= load_unit_pkg::LOAD_MAR;
                        busy      <= 1'b1;
                        write_mar <= 1'b1;
                    end
                end
                load_unit_pkg::LOAD_MAR: begin
                    start <= 1'b1;    // MAR is loaded at this edge.
                    state <= load_unit_pkg::WAIT_DONE;
                end
                load_unit_pkg::WAIT_DONE: begin
                    if (complete) begin
                        busy  <= 1'b0;
                        state <= load_unit_pkg::READY;
                    end
                end
                default: begin
                    state <= load_unit_pkg::READY;
                end
            endcase
        end
    end

    // Operands stay put until the next accepted load.
    always_ff @(posedge clk) begin
        if (accept && is_load) begin
            mar_in  <= cmd.offset;
            segment <= seg_regs[cmd.seg];
            is_8bit <= (cmd.opcode == load_unit_pkg::LOAD_BYTE);
        end
    end

endmodule

//--- hdl/load_unit_pkg.sv
`include "load_unit_params.svh"

package load_unit_pkg;

    // ##############################
    // Encodings
    // ##############################

    typedef enum logic [1:0] {
        LOAD_BYTE,
        LOAD_WORD,
        SET_SEGMENT
    } lu_opcode_e;

    typedef enum logic [1:0] {
        SEG_ES,
        SEG_CS,
        SEG_SS,
        SEG_DS
    } lu_seg_e;

    typedef enum logic [1:0] {
        IDLE,
        FIRST,
        SECOND,
        DONE
    } lu_seq_state_e;

    typedef enum logic [1:0] {
        READY,
        LOAD_MAR,
        WAIT_DONE
    } lu_front_state_e;

    // ##############################
    // Bundles
    // ##############################

    typedef struct packed {
        lu_opcode_e              opcode;
        lu_seg_e                 seg;
        logic [`LU_OFFSET_W-1:0] offset;
        logic [`LU_OFFSET_W-1:0] data;    // New segment value for SET_SEGMENT.
    } lu_cmd_t;

    typedef struct packed {
        logic [`LU_PADDR_W-2:0] addr;     // Word address.
        logic                   read;
    } lu_bus_req_t;

endpackage

//--- hdl/load_unit_params.svh
`ifndef LOAD_UNIT_PARAMS_SVH
`define LOAD_UNIT_PARAMS_SVH

// ##############################
// Address geometry
// ##############################

`define LU_OFFSET_W  16   // Segment and offset registers are one CPU word wide.
`define LU_PADDR_W   20   // Physical byte address; the word address is bits 19..1.

// ##############################
// Register file and bus
// ##############################

`define LU_SEG_COUNT 4    // ES, CS, SS and DS.
`define LU_MAX_WAIT  3    // Longest wait-state run seen on the external bus.

`endif
